/* Makefile */
# Verilator flow for the integer execution unit testbench

VERILATOR ?= verilator
TOP       ?= tb_ieu
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rtl/cdb_arbiter.sv */
// round-robin arbiter that registers one lane result per cycle onto the common data bus
`timescale 1ns/100ps

module cdb_arbiter import ieu_pkg::*; (
    input  logic                 clk,
    input  logic                 n_rst,
    input  logic                 i_flush,
    input  cdb_t                 i_results [NUM_LANES],
    output logic [NUM_LANES-1:0] o_grant,
    output cdb_t                 o_cdb
);

    logic [LANE_IDX_WIDTH-1:0] ptr; // lane with highest priority this cycle
    logic [LANE_IDX_WIDTH-1:0] win;
    logic [NUM_LANES-1:0]      grant;

    // scan the lanes starting at the pointer, first valid one wins
    always_comb begin
        int lane;
        grant = '0;
        win   = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            lane = (int'(ptr) + k) % NUM_LANES;
            if (i_results[lane].valid && grant == '0) begin
                grant[lane] = 1'b1;
                win         = LANE_IDX_WIDTH'(lane);
            end
        end
    end

    assign o_grant = i_flush ? '0 : grant;

    always_ff @(posedge clk) begin
        if (|o_grant) begin
            o_cdb.tag           <= i_results[win].tag;
            o_cdb.data          <= i_results[win].data;
            o_cdb.redirect      <= i_results[win].redirect;
            o_cdb.redirect_addr <= i_results[win].redirect_addr;
        end
        if (!n_rst) begin
            o_cdb.valid <= 1'b0;
            ptr         <= '0;
        end else begin
            o_cdb.valid <= |o_grant;
            if (|o_grant) ptr <= LANE_IDX_WIDTH'((int'(win) + 1) % NUM_LANES);
        end
    end

    a_grant_onehot0: assert property (@(posedge clk) disable iff (!n_rst)
        $onehot0(o_grant));

endmodule

/* rtl/ieu_ex.sv */
// execute stage of one lane, holds its bus result until the arbiter grants it
`timescale 1ns/100ps

module ieu_ex import ieu_pkg::*; (
    input  logic   clk,
    input  logic   n_rst,
    input  logic   i_flush,
    input  id_ex_t i_id_ex,
    input  logic   i_grant,
    output cdb_t   o_result,
    output logic   o_stall
);

    logic [DATA_WIDTH-1:0] alu_res;
    logic [ADDR_WIDTH-1:0] link_addr;
    logic [ADDR_WIDTH-1:0] br_target;
    logic [DATA_WIDTH-1:0] data_nx;
    logic                  redirect_nx;
    logic [ADDR_WIDTH-1:0] redirect_addr_nx;
    logic                  load;

    always_comb begin
        case (i_id_ex.alu_func)
            ADD:     alu_res = i_id_ex.src_a + i_id_ex.src_b;
            SUB:     alu_res = i_id_ex.src_a - i_id_ex.src_b;
            SLL:     alu_res = i_id_ex.src_a << i_id_ex.shamt;
            SRL:     alu_res = i_id_ex.src_a >> i_id_ex.shamt;
            SRA:     alu_res = $signed(i_id_ex.src_a) >>> i_id_ex.shamt;
            AND:     alu_res = i_id_ex.src_a & i_id_ex.src_b;
            OR:      alu_res = i_id_ex.src_a | i_id_ex.src_b;
            XOR:     alu_res = i_id_ex.src_a ^ i_id_ex.src_b;
            // compares leave a single flag in bit 0
            LT:      alu_res = DATA_WIDTH'($signed(i_id_ex.src_a) < $signed(i_id_ex.src_b));
            LTU:     alu_res = DATA_WIDTH'(i_id_ex.src_a < i_id_ex.src_b);
            EQ:      alu_res = DATA_WIDTH'(i_id_ex.src_a == i_id_ex.src_b);
            NE:      alu_res = DATA_WIDTH'(i_id_ex.src_a != i_id_ex.src_b);
            GE:      alu_res = DATA_WIDTH'($signed(i_id_ex.src_a) >= $signed(i_id_ex.src_b));
            GEU:     alu_res = DATA_WIDTH'(i_id_ex.src_a >= i_id_ex.src_b);
            default: alu_res = '0;
        endcase
    end

    assign link_addr = i_id_ex.iaddr + ADDR_WIDTH'(4);
    assign br_target = i_id_ex.iaddr + i_id_ex.imm_b;

    always_comb begin
        data_nx          = alu_res;
        redirect_nx      = 1'b0;
        redirect_addr_nx = br_target;
        if (i_id_ex.jmp) begin
            data_nx          = link_addr;
            redirect_nx      = 1'b1;
            redirect_addr_nx = {alu_res[ADDR_WIDTH-1:1], 1'b0}; // jump target is the adder sum
        end else if (i_id_ex.br) begin
            data_nx     = '0;
            redirect_nx = alu_res[0];
        end
    end

    assign load    = !o_result.valid || i_grant; // register empty or leaving this cycle
    assign o_stall = o_result.valid && !i_grant;

    always_ff @(posedge clk) begin
        if (load) begin
            o_result.tag           <= i_id_ex.tag;
            o_result.data          <= data_nx;
            o_result.redirect      <= redirect_nx;
            o_result.redirect_addr <= redirect_addr_nx;
        end
        if (!n_rst || i_flush) o_result.valid <= 1'b0;
        else if (load)         o_result.valid <= i_id_ex.valid;
    end

    a_hold_ungranted: assert property (@(posedge clk) disable iff (!n_rst)
        (o_result.valid && !i_grant && !i_flush) |=> $stable(o_result));

endmodule

/* rtl/ieu_id.sv */
// decode stage that ieu_top instantiates once per lane to turn an issued operation into a registered execute bundle
`timescale 1ns/100ps

module ieu_id import ieu_pkg::*; (
    input  logic   clk,
    input  logic   n_rst,
    input  logic   i_flush,
    input  logic   i_stall,
    input  issue_t i_issue,
    output id_ex_t o_id_ex
);

    logic                  is_op;
    logic                  is_opimm;
    logic                  is_lui;
    logic                  is_auipc;
    logic                  is_jal;
    logic                  is_jalr;
    logic                  is_br;
    logic [2:0]            funct3;
    logic                  bit30;
    alu_func_e             alu_func;
    logic [DATA_WIDTH-1:0] op_a;
    logic [DATA_WIDTH-1:0] op_b;

    assign is_op    = i_issue.opcode == OPC_OP;
    assign is_opimm = i_issue.opcode == OPC_OPIMM;
    assign is_lui   = i_issue.opcode == OPC_LUI;
    assign is_auipc = i_issue.opcode == OPC_AUIPC;
    assign is_jal   = i_issue.opcode == OPC_JAL;
    assign is_jalr  = i_issue.opcode == OPC_JALR;
    assign is_br    = i_issue.opcode == OPC_BRANCH;

    assign funct3 = i_issue.insn.insn_r.funct3;
    assign bit30  = i_issue.insn.insn_r.funct7[5]; // picks SUB and SRA

    always_comb begin
        alu_func = ADD; // jumps, LUI and AUIPC only need the adder
        if (is_br) begin
            case (funct3)
                3'b000:  alu_func = EQ;
                3'b001:  alu_func = NE;
                3'b100:  alu_func = LT;
                3'b101:  alu_func = GE;
                3'b110:  alu_func = LTU;
                3'b111:  alu_func = GEU;
                default: alu_func = ADD;
            endcase
        end else if (is_op || is_opimm) begin
            case (funct3)
                3'b000:  alu_func = (is_op && bit30) ? SUB : ADD; // ADDI has no SUB form
                3'b001:  alu_func = SLL;
                3'b010:  alu_func = LT;
                3'b011:  alu_func = LTU;
                3'b100:  alu_func = XOR;
                3'b101:  alu_func = bit30 ? SRA : SRL;
                3'b110:  alu_func = OR;
                default: alu_func = AND;
            endcase
        end
    end

    always_comb begin
        if (is_lui)                  op_a = '0;
        else if (is_auipc || is_jal) op_a = i_issue.iaddr;
        else                         op_a = i_issue.src_a;

        if (is_op || is_br)          op_b = i_issue.src_b;
        else if (is_opimm || is_jalr) op_b = imm_i(i_issue.insn);
        else if (is_jal)             op_b = imm_j(i_issue.insn);
        else                         op_b = imm_u(i_issue.insn);
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_id_ex.alu_func <= alu_func;
            o_id_ex.src_a    <= op_a;
            o_id_ex.src_b    <= op_b;
            o_id_ex.iaddr    <= i_issue.iaddr;
            o_id_ex.imm_b    <= imm_b(i_issue.insn);
            o_id_ex.shamt    <= is_op ? i_issue.src_b[SHAMT_WIDTH-1:0] : i_issue.insn.insn_r.rs2;
            o_id_ex.tag      <= i_issue.tag;
            o_id_ex.jmp      <= is_jal | is_jalr;
            o_id_ex.br       <= is_br & (funct3 != 3'b010) & (funct3 != 3'b011);
        end
        if (!n_rst || i_flush) begin
            o_id_ex.valid <= 1'b0;
        end else if (!i_stall) begin
            o_id_ex.valid <= i_issue.valid;
        end
    end

    // a stalled decode register cannot take a new operation
    a_no_issue_stall: assert property (@(posedge clk) disable iff (!n_rst)
        (i_stall && !i_flush) |-> !i_issue.valid);

endmodule

/* rtl/ieu_pkg.sv */
// widths, encodings and stage bundles shared by the integer execution unit; import with ieu_pkg::*
package ieu_pkg;

    localparam int DATA_WIDTH     = 32;
    localparam int ADDR_WIDTH     = 32;
    localparam int TAG_WIDTH      = 5;
    localparam int NUM_LANES      = 2;
    localparam int LANE_IDX_WIDTH = $clog2(NUM_LANES);
    localparam int SHAMT_WIDTH    = 5;
    localparam int OPC_WIDTH      = 7;

    localparam logic [OPC_WIDTH-1:0] OPC_OP     = 7'b0110011;
    localparam logic [OPC_WIDTH-1:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [OPC_WIDTH-1:0] OPC_LUI    = 7'b0110111;
    localparam logic [OPC_WIDTH-1:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [OPC_WIDTH-1:0] OPC_JAL    = 7'b1101111;
    localparam logic [OPC_WIDTH-1:0] OPC_JALR   = 7'b1100111;
    localparam logic [OPC_WIDTH-1:0] OPC_BRANCH = 7'b1100011;

    // branch LT and LTU share the set-less-than codes
    typedef enum logic [3:0] {
        ADD, SUB, SLL, SRL, SRA, AND, OR, XOR,
        LT, LTU, EQ, NE, GE, GEU
    } alu_func_e;

    typedef struct packed {
        logic [6:0]           funct7;
        logic [4:0]           rs2;
        logic [4:0]           rs1;
        logic [2:0]           funct3;
        logic [4:0]           rd;
        logic [OPC_WIDTH-1:0] opcode;
    } insn_r_t;

    typedef struct packed {
        logic [11:0]          imm_11_0;
        logic [4:0]           rs1;
        logic [2:0]           funct3;
        logic [4:0]           rd;
        logic [OPC_WIDTH-1:0] opcode;
    } insn_i_t;

    typedef struct packed {
        logic                 imm_12;
        logic [5:0]           imm_10_5;
        logic [4:0]           rs2;
        logic [4:0]           rs1;
        logic [2:0]           funct3;
        logic [3:0]           imm_4_1;
        logic                 imm_11;
        logic [OPC_WIDTH-1:0] opcode;
    } insn_b_t;

    typedef struct packed {
        logic [19:0]          imm_31_12;
        logic [4:0]           rd;
        logic [OPC_WIDTH-1:0] opcode;
    } insn_u_t;

    typedef struct packed {
        logic                 imm_20;
        logic [9:0]           imm_10_1;
        logic                 imm_11;
        logic [7:0]           imm_19_12;
        logic [4:0]           rd;
        logic [OPC_WIDTH-1:0] opcode;
    } insn_j_t;

    typedef union packed {
        insn_r_t insn_r;
        insn_i_t insn_i;
        insn_b_t insn_b;
        insn_u_t insn_u;
        insn_j_t insn_j;
    } insn_t;

    typedef struct packed {
        logic                  valid;
        logic [OPC_WIDTH-1:0]  opcode;
        logic [ADDR_WIDTH-1:0] iaddr;
        insn_t                 insn;
        logic [DATA_WIDTH-1:0] src_a;
        logic [DATA_WIDTH-1:0] src_b;
        logic [TAG_WIDTH-1:0]  tag;
    } issue_t;

    typedef struct packed {
        logic                   valid;
        alu_func_e              alu_func;
        logic [DATA_WIDTH-1:0]  src_a;
        logic [DATA_WIDTH-1:0]  src_b;
        logic [ADDR_WIDTH-1:0]  iaddr;
        logic [DATA_WIDTH-1:0]  imm_b;
        logic [SHAMT_WIDTH-1:0] shamt;
        logic [TAG_WIDTH-1:0]   tag;
        logic                   jmp;
        logic                   br;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic [TAG_WIDTH-1:0]  tag;
        logic [DATA_WIDTH-1:0] data;
        logic                  redirect;
        logic [ADDR_WIDTH-1:0] redirect_addr;
    } cdb_t;

    // sign-extended immediates, one per instruction format
    function automatic logic [DATA_WIDTH-1:0] imm_i(input insn_t insn);
        return {{(DATA_WIDTH-12){insn.insn_i.imm_11_0[11]}}, insn.insn_i.imm_11_0};
    endfunction

    function automatic logic [DATA_WIDTH-1:0] imm_b(input insn_t insn);
        return {{(DATA_WIDTH-12){insn.insn_b.imm_12}}, insn.insn_b.imm_11,
                insn.insn_b.imm_10_5, insn.insn_b.imm_4_1, 1'b0};
    endfunction

    function automatic logic [DATA_WIDTH-1:0] imm_u(input insn_t insn);
        return {insn.insn_u.imm_31_12, {(DATA_WIDTH-20){1'b0}}};
    endfunction

    function automatic logic [DATA_WIDTH-1:0] imm_j(input insn_t insn);
        return {{(DATA_WIDTH-20){insn.insn_j.imm_20}}, insn.insn_j.imm_19_12,
                insn.insn_j.imm_11, insn.insn_j.imm_10_1, 1'b0};
    endfunction

endpackage

/* rtl/ieu_top.sv */
// integer execution unit top, two decode and execute lanes sharing one common data bus
`timescale 1ns/100ps

module ieu_top import ieu_pkg::*; (
    input  logic                 clk,
    input  logic                 n_rst,
    input  logic                 i_flush,
    input  issue_t               i_issue [NUM_LANES],
    output logic [NUM_LANES-1:0] o_busy,
    output cdb_t                 o_cdb
);

    id_ex_t               id_ex  [NUM_LANES];
    cdb_t                 result [NUM_LANES];
    logic [NUM_LANES-1:0] grant;

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        // the busy level doubles as the stall of the lane
        ieu_id id_i (
            .clk     (clk),
            .n_rst   (n_rst),
            .i_flush (i_flush),
            .i_stall (o_busy[g]),
            .i_issue (i_issue[g]),
            .o_id_ex (id_ex[g])
        );

        ieu_ex ex_i (
            .clk      (clk),
            .n_rst    (n_rst),
            .i_flush  (i_flush),
            .i_id_ex  (id_ex[g]),
            .i_grant  (grant[g]),
            .o_result (result[g]),
            .o_stall  (o_busy[g])
        );
    end

    cdb_arbiter arb_i (
        .clk       (clk),
        .n_rst     (n_rst),
        .i_flush   (i_flush),
        .i_results (result),
        .o_grant   (grant),
        .o_cdb     (o_cdb)
    );

endmodule

/* sim.f */
rtl/ieu_pkg.sv
rtl/ieu_id.sv
rtl/ieu_ex.sv
rtl/cdb_arbiter.sv
rtl/ieu_top.sv
tests/tb_clock.sv
tests/tb_ieu.sv

/* tests/tb_clock.sv */
// clock and reset source for the testbench, instantiate once in the testbench top
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic n_rst
);

    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 8;
    localparam int DRIVE_DELAY  = 1;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        n_rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY n_rst = 1'b1; // released off the edge like every other input
    end

endmodule

/* tests/tb_ieu.sv */
// simulation top that drives ieu_top with random operations on both lanes and checks every bus word against a reference model
`timescale 1ns/100ps

module tb_ieu import ieu_pkg::*; ();

    localparam int TAGS        = 1 << TAG_WIDTH;
    localparam int NUM_LONE    = 24;
    localparam int NUM_ISSUES  = 600;
    localparam int FLUSH_EVERY = 97;
    localparam int LATENCY     = 3;
    localparam int DRIVE_DELAY = 1;
    // a lone issue drains in about five cycles and the burst needs about one per issue
    localparam int MAX_CYCLES  = NUM_ISSUES * 6 + 400;

    logic                 clk;
    logic                 n_rst;
    logic                 flush;
    issue_t               issue [NUM_LANES];
    logic [NUM_LANES-1:0] busy;
    cdb_t                 cdb;

    int                   seed;
    int                   cyc        = 0;
    int                   issued     = 0;
    int                   retired    = 0;
    int                   killed_cnt = 0;
    logic [TAG_WIDTH-1:0] next_tag   = '0;
    logic                 after_flush = 1'b0;
    logic                 lone_phase  = 1'b0;

    // bookkeeping per tag
    cdb_t                 expected  [TAGS];
    logic                 pending   [TAGS];
    logic                 killed    [TAGS];
    logic                 is_lone   [TAGS];
    int                   issue_cyc [TAGS];

    tb_clock clock_i (
        .clk   (clk),
        .n_rst (n_rst)
    );

    ieu_top dut_i (
        .clk     (clk),
        .n_rst   (n_rst),
        .i_flush (flush),
        .i_issue (issue),
        .o_busy  (busy),
        .o_cdb   (cdb)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    function automatic int outstanding();
        return issued - retired - killed_cnt;
    endfunction

    function automatic logic [OPC_WIDTH-1:0] opcode_of(input int sel);
        case (sel)
            0:       return OPC_OP;
            1:       return OPC_OPIMM;
            2:       return OPC_LUI;
            3:       return OPC_AUIPC;
            4:       return OPC_JAL;
            5:       return OPC_JALR;
            default: return OPC_BRANCH;
        endcase
    endfunction

    // expected bus word with the immediates taken straight from the instruction bits
    function automatic cdb_t model_result(input issue_t op);
        cdb_t                  res;
        logic [31:0]           w;
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        logic [DATA_WIDTH-1:0] i_imm;
        logic [DATA_WIDTH-1:0] b_imm;
        logic [DATA_WIDTH-1:0] u_imm;
        logic [DATA_WIDTH-1:0] j_imm;
        logic [4:0]            sh;
        logic                  reg_op;
        w      = op.insn;
        i_imm  = {{20{w[31]}}, w[31:20]};
        b_imm  = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        u_imm  = {w[31:12], 12'h000};
        j_imm  = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        reg_op = op.opcode == OPC_OP;
        a      = op.src_a;
        b      = reg_op ? op.src_b : i_imm;
        sh     = reg_op ? op.src_b[4:0] : w[24:20];
        res       = '0;
        res.valid = 1'b1;
        res.tag   = op.tag;
        case (op.opcode)
            OPC_OP, OPC_OPIMM: begin
                case (w[14:12])
                    3'b000:  res.data = (reg_op && w[30]) ? a - b : a + b;
                    3'b001:  res.data = a << sh;
                    3'b010:  res.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b011:  res.data = (a < b) ? 32'd1 : 32'd0;
                    3'b100:  res.data = a ^ b;
                    3'b101: begin
                        if (w[30]) res.data = $signed(a) >>> sh;
                        else       res.data = a >> sh;
                    end
                    3'b110:  res.data = a | b;
                    default: res.data = a & b;
                endcase
            end
            OPC_LUI:   res.data = u_imm;
            OPC_AUIPC: res.data = op.iaddr + u_imm;
            OPC_JAL, OPC_JALR: begin
                res.data          = op.iaddr + 32'd4;
                res.redirect      = 1'b1;
                res.redirect_addr = (op.opcode == OPC_JAL) ? op.iaddr + j_imm : a + i_imm;
                res.redirect_addr[0] = 1'b0;
            end
            default: begin
                b = op.src_b; // a conditional branch leaves the data at zero
                case (w[14:12])
                    3'b000:  res.redirect = a == b;
                    3'b001:  res.redirect = a != b;
                    3'b100:  res.redirect = $signed(a) < $signed(b);
                    3'b101:  res.redirect = $signed(a) >= $signed(b);
                    3'b110:  res.redirect = a < b;
                    default: res.redirect = a >= b;
                endcase
                res.redirect_addr = op.iaddr + b_imm;
            end
        endcase
        return res;
    endfunction

    task automatic make_op(input logic [TAG_WIDTH-1:0] tag, output issue_t op);
        int sel;
        sel           = int'($unsigned($random(seed)) % 7);
        op            = '0;
        op.valid      = 1'b1;
        op.opcode     = opcode_of(sel);
        op.iaddr      = ADDR_WIDTH'($random(seed));
        op.iaddr[1:0] = 2'b00;
        op.insn       = insn_t'($random(seed));
        op.insn.insn_r.opcode = op.opcode;
        if (op.opcode == OPC_BRANCH) begin
            sel = int'($unsigned($random(seed)) % 6);
            op.insn.insn_b.funct3 = 3'(sel < 2 ? sel : sel + 2); // skips 010 and 011
        end
        op.src_a = DATA_WIDTH'($random(seed));
        sel      = int'($unsigned($random(seed)) % 4);
        if (sel == 0) op.src_b = op.src_a; // equal operands so EQ and GE get taken
        else          op.src_b = DATA_WIDTH'($random(seed));
        op.tag = tag;
    endtask

    task automatic issue_op(input int lane, input logic lone);
        issue_t op;
        make_op(next_tag, op);
        assert (!pending[next_tag]) else
            report_failure($sformatf("tag %0d never left the unit before its reuse", next_tag));
        expected[next_tag]  = model_result(op);
        pending[next_tag]   = 1'b1;
        killed[next_tag]    = 1'b0;
        is_lone[next_tag]   = lone;
        issue_cyc[next_tag] = cyc;
        issue[lane]         = op;
        issued++;
        next_tag = next_tag + 1'b1;
    endtask

    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
        flush = 1'b0;
        for (int l = 0; l < NUM_LANES; l++) begin
            issue[l].valid = 1'b0;
        end
    endtask

    task automatic wait_idle();
        while (outstanding() != 0) begin
            step();
        end
    endtask

    task automatic kill_outstanding();
        for (int t = 0; t < TAGS; t++) begin
            if (pending[t]) begin
                pending[t] = 1'b0;
                killed[t]  = 1'b1;
                killed_cnt++;
            end
        end
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) report_failure($sformatf("timeout after %0d cycles", cyc));
    end

    // bus and input checks run half a cycle away from both edges
    always @(negedge clk) begin
        cdb_t                 want;
        logic [TAG_WIDTH-1:0] t;
        if (n_rst !== 1'b1) begin
            assert (cyc == 0 || !cdb.valid) else
                report_failure("o_cdb.valid is high during reset");
        end else begin
            assert (!(after_flush && cdb.valid)) else
                report_failure("o_cdb.valid is high in the cycle after a flush");
            // no lane can stall right after a flush or while a single operation is in flight
            assert (!(after_flush || lone_phase) || busy == '0) else
                report_failure($sformatf("Error: o_busy got %h expected %h",
                    busy, NUM_LANES'(0)));
            for (int l = 0; l < NUM_LANES; l++) begin
                assert (!(issue[l].valid && busy[l])) else
                    report_failure($sformatf("operation issued to busy lane %0d", l));
            end
            if (cdb.valid) begin
                t    = cdb.tag;
                want = expected[t];
                assert (!killed[t]) else
                    report_failure($sformatf("flushed tag %0d reached o_cdb", t));
                assert (pending[t]) else
                    report_failure($sformatf("tag %0d on o_cdb without an open issue", t));
                assert (cdb.data == want.data) else report_failure($sformatf(
                    "Error: o_cdb.data tag %h got %h expected %h", t, cdb.data, want.data));
                assert (cdb.redirect == want.redirect) else report_failure($sformatf(
                    "Error: o_cdb.redirect tag %h got %h expected %h",
                    t, cdb.redirect, want.redirect));
                assert (!want.redirect || cdb.redirect_addr == want.redirect_addr) else
                    report_failure($sformatf("Error: o_cdb.redirect_addr tag %h got %h expected %h",
                        t, cdb.redirect_addr, want.redirect_addr));
                assert (!is_lone[t] || cyc == issue_cyc[t] + LATENCY) else
                    report_failure($sformatf("Error: o_cdb latency tag %h got %h expected %h",
                        t, cyc - issue_cyc[t], LATENCY));
                pending[t] = 1'b0;
                retired++;
            end
            after_flush = flush;
            if (flush) kill_outstanding(); // whatever is still inside dies at this edge
        end
    end

    initial begin
        int burst_cyc;
        seed  = 32'h08d02614;
        flush = 1'b0;
        for (int l = 0; l < NUM_LANES; l++) begin
            issue[l] = '0;
        end
        for (int t = 0; t < TAGS; t++) begin
            pending[t] = 1'b0;
            killed[t]  = 1'b0;
            is_lone[t] = 1'b0;
        end
        burst_cyc = 0;
        wait (n_rst === 1'b1);

        // one operation at a time into an empty unit
        lone_phase = 1'b1;
        for (int i = 0; i < NUM_LONE; i++) begin
            wait_idle();
            step();
            issue_op(i % NUM_LANES, 1'b1);
        end
        wait_idle();
        lone_phase = 1'b0;

        // both lanes issue whenever they are free and a flush comes now and then
        while (issued < NUM_ISSUES) begin
            step();
            burst_cyc++;
            if (burst_cyc % FLUSH_EVERY == 0) begin
                flush = 1'b1;
            end else begin
                for (int l = 0; l < NUM_LANES; l++) begin
                    if (!busy[l] && issued < NUM_ISSUES) issue_op(l, 1'b0);
                end
            end
        end
        step();
        wait_idle();

        $display("Done: no errors");
        $finish;
    end

endmodule
